/* Makefile */
SIM      := verilator
FLAGS    := --binary --timing --assert --timescale 1ns/1ns
TOP      := fdtd_tb
FILELIST := vlog.f
OBJ_DIR  := obj_dir
LOG      := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, fail if the log reports failure"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   list these targets"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TB FAILED" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "TB PASSED" $(LOG); then echo "simulation ended early"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* bench/fdtd_mem_ctrl_chk.sv */
`timescale 1ns/1ns

module fdtd_mem_ctrl_chk
    import fdtd_cfg_pkg::*;
    import fdtd_bus_pkg::*;
(
    input logic      ACLK,
    input logic      ARESETn,
    input logic      busy_o,
    input logic      mem_req_o,
    input mem_cmd_t  mem_cmd_o,
    input logic      mem_ack_i,
    input logic      calc_req_o,
    input calc_cmd_t calc_cmd_o,
    input logic      calc_ack_i,
    input logic      upd_req_o,
    input upd_cmd_t  upd_cmd_o,
    input logic      upd_ack_i
);

    int fail_cnt = 0;

    ////////////////////////////////////////////////////////////
    // four-phase rules per channel
    ////////////////////////////////////////////////////////////

    mem_hold: assert property (@(posedge ACLK) disable iff (!ARESETn)
        mem_req_o && !mem_ack_i |=> mem_req_o && $stable(mem_cmd_o))
        else begin $error("mem req dropped or payload changed before ack"); fail_cnt++; end
    calc_hold: assert property (@(posedge ACLK) disable iff (!ARESETn)
        calc_req_o && !calc_ack_i |=> calc_req_o && $stable(calc_cmd_o))
        else begin $error("calc req dropped or payload changed before ack"); fail_cnt++; end
    upd_hold: assert property (@(posedge ACLK) disable iff (!ARESETn)
        upd_req_o && !upd_ack_i |=> upd_req_o && $stable(upd_cmd_o))
        else begin $error("upd req dropped or payload changed before ack"); fail_cnt++; end

    // new request only once the old ack is gone
    mem_rise: assert property (@(posedge ACLK) disable iff (!ARESETn)
        $rose(mem_req_o) |-> !mem_ack_i)
        else begin $error("mem req rose while ack high"); fail_cnt++; end
    calc_rise: assert property (@(posedge ACLK) disable iff (!ARESETn)
        $rose(calc_req_o) |-> !calc_ack_i)
        else begin $error("calc req rose while ack high"); fail_cnt++; end
    upd_rise: assert property (@(posedge ACLK) disable iff (!ARESETn)
        $rose(upd_req_o) |-> !upd_ack_i)
        else begin $error("upd req rose while ack high"); fail_cnt++; end

    reset_idle: assert property (@(posedge ACLK) $rose(ARESETn) |-> !busy_o)
        else begin $error("busy high coming out of reset"); fail_cnt++; end

endmodule

bind fdtd_mem_ctrl fdtd_mem_ctrl_chk u_chk
(
    .ACLK(ACLK), .ARESETn(ARESETn), .busy_o(busy_o),
    .mem_req_o(mem_req_o), .mem_cmd_o(mem_cmd_o), .mem_ack_i(mem_ack_i),
    .calc_req_o(calc_req_o), .calc_cmd_o(calc_cmd_o), .calc_ack_i(calc_ack_i),
    .upd_req_o(upd_req_o), .upd_cmd_o(upd_cmd_o), .upd_ack_i(upd_ack_i)
);

/* bench/fdtd_tb.sv */
`timescale 1ns/1ns

module fdtd_tb
    import fdtd_cfg_pkg::*;
    import fdtd_bus_pkg::*;
();

    localparam int BLOCK_WORDS    = 8;
    localparam int HALF_PERIOD    = 20;
    localparam int RESET_CYCLES   = 16;
    localparam int MEM_WORDS      = 1 << ADDR_W;
    localparam int IRQ_WORDS      = 4;
    // two reads and two write-backs per index over all sweeps
    localparam int WORDS_MOVED    = 4 * (BLOCK_WORDS + (2 * BLOCK_WORDS + 3) + IRQ_WORDS
                                         + BLOCK_WORDS);
    localparam int TIMEOUT_CYCLES = 40 * WORDS_MOVED + 500;

    logic      ACLK;
    logic      ARESETn;
    logic      start_i;
    run_cfg_t  cfg_i;
    logic      int_en_i;
    logic      clr_int_i;
    logic      busy_o;
    logic      int_pending_o;
    logic      int_o;
    logic      mem_req_o;
    mem_cmd_t  mem_cmd_o;
    logic      mem_ack_i   = 1'b0;
    word_t     mem_rdata_i = '0;
    logic      calc_req_o;
    calc_cmd_t calc_cmd_o;
    logic      calc_ack_i  = 1'b0;
    logic      upd_req_o;
    upd_cmd_t  upd_cmd_o;
    logic      upd_ack_i   = 1'b0;
    word_t     upd_data_i  = '0;
    old_word_t old_word_o;

    word_t       mem [0:MEM_WORDS-1];
    word_t       old_hy [0:BLOCK_WORDS-1];
    word_t       old_ez [0:BLOCK_WORDS-1];
    word_t       new_hy [0:BLOCK_WORDS-1];
    word_t       new_ez [0:BLOCK_WORDS-1];
    int          mem_wait  = 0;
    bit          rand_dly  = 1'b0;
    logic [31:0] lcg_state = 32'h2efa;
    run_cfg_t    eng_cfg;
    int          blk_no;
    int          stream_cnt;
    int          err_count = 0;
    string       test_name = "reset";

    fdtd_mem_ctrl #(.BLOCK_WORDS(BLOCK_WORDS)) u_fdtd_mem_ctrl (.*);

    initial
    begin
        ACLK = 1'b0;
        forever #HALF_PERIOD ACLK = ~ACLK;
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // initial memory image unique per address
    function automatic word_t fill_word(input addr_t a);
        return {a ^ 16'h5ac3, a} + 32'h0137_f00d;
    endfunction

    function automatic int block_len(input int blk);
        int left;
        left = int'(eng_cfg.count) - blk * BLOCK_WORDS;
        return (left < BLOCK_WORDS) ? left : BLOCK_WORDS;
    endfunction

    task automatic check_word(input string what, input word_t exp, input word_t act);
        if (exp !== act)
        begin
            err_count++;
            $display("mismatch %s %s: expected %h actual %h", test_name, what, exp, act);
        end
    endtask

    task automatic check_field(input string what, input field_e exp, input field_e act);
        if (exp !== act)
        begin
            err_count++;
            $display("mismatch %s %s: expected %s actual %s", test_name, what,
                     exp.name(), act.name());
        end
    endtask

    task automatic check_bit(input string what, input logic exp, input logic act);
        if (exp !== act)
        begin
            err_count++;
            $display("mismatch %s %s: expected %b actual %b", test_name, what, exp, act);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // memory model as four-phase responder
    ////////////////////////////////////////////////////////////

    initial
    begin
        for (int a = 0; a < MEM_WORDS; a++)
            mem[a] = fill_word(addr_t'(a));
        forever
        begin
            @(posedge ACLK);
            if (mem_ack_i)
            begin
                if (!mem_req_o)
                    mem_ack_i <= 1'b0;
            end
            else if (mem_req_o)
            begin
                if (mem_wait > 0)
                    mem_wait--;
                else
                begin
                    mem_ack_i <= 1'b1;
                    if (mem_cmd_o.wr)
                        mem[mem_cmd_o.addr] = mem_cmd_o.data;
                    else
                        mem_rdata_i <= mem[mem_cmd_o.addr];
                    // 0 to 3 wait cycles before the next ack
                    mem_wait = rand_dly ? int'(lcg_next() >> 30) : 0;
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // compute engine model
    ////////////////////////////////////////////////////////////

    task automatic take_old_word(input old_word_t w);
        int     len;
        int     exp_idx;
        field_e exp_field;
        addr_t  base;
        len       = block_len(blk_no);
        exp_field = (stream_cnt < len) ? HY : EZ;
        exp_idx   = (stream_cnt < len) ? stream_cnt : stream_cnt - len;
        base      = (exp_field == HY) ? eng_cfg.hy_base : eng_cfg.ez_base;
        check_field("stream field", exp_field, w.field);
        check_word("stream index", word_t'(exp_idx), word_t'(w.idx));
        check_word("stream data", fill_word(base + addr_t'(blk_no * BLOCK_WORDS + exp_idx)),
                   w.data);
        if (w.field == HY)
            old_hy[int'(w.idx)] = w.data;
        else
            old_ez[int'(w.idx)] = w.data;
        stream_cnt++;
    endtask

    initial
    begin
        forever
        begin
            @(posedge ACLK);
            // config of the coming run
            if (!busy_o)
            begin
                eng_cfg    = cfg_i;
                blk_no     = 0;
                stream_cnt = 0;
            end
            if (old_word_o.valid)
                take_old_word(old_word_o);
            if (calc_ack_i)
            begin
                if (!calc_req_o)
                    calc_ack_i <= 1'b0;
            end
            else if (calc_req_o)
            begin
                check_word("calc length", word_t'(block_len(blk_no)), word_t'(calc_cmd_o.len));
                check_word("words streamed", word_t'(2 * block_len(blk_no)),
                           word_t'(stream_cnt));
                for (int i = 0; i < BLOCK_WORDS; i++)
                begin
                    new_hy[i] = old_hy[i] + old_ez[i];
                    new_ez[i] = old_ez[i] - old_hy[i];
                end
                blk_no++;
                stream_cnt = 0;
                calc_ack_i <= 1'b1;
            end
            if (upd_ack_i)
            begin
                if (!upd_req_o)
                    upd_ack_i <= 1'b0;
            end
            else if (upd_req_o)
            begin
                upd_ack_i  <= 1'b1;
                upd_data_i <= (upd_cmd_o.field == HY) ? new_hy[int'(upd_cmd_o.idx)]
                                                      : new_ez[int'(upd_cmd_o.idx)];
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // sweep helpers
    ////////////////////////////////////////////////////////////

    task automatic start_sweep(input run_cfg_t c);
        @(posedge ACLK);
        cfg_i   <= c;
        start_i <= 1'b1;
        @(posedge ACLK);
        start_i <= 1'b0;
    endtask

    task automatic wait_busy();
        do
            @(negedge ACLK);
        while (!busy_o);
    endtask

    // pending flag settles a cycle after busy falls
    task automatic wait_sweep_end();
        while (busy_o)
            @(negedge ACLK);
        repeat (2) @(negedge ACLK);
    endtask

    task automatic run_sweep(input run_cfg_t c);
        start_sweep(c);
        wait_busy();
        wait_sweep_end();
    endtask

    task automatic check_guards(input addr_t base, input count_t n);
        addr_t below;
        addr_t above;
        below = base - 16'd1;
        above = base + n;
        check_word("guard below", fill_word(below), mem[below]);
        check_word("guard above", fill_word(above), mem[above]);
    endtask

    task automatic check_arrays(input run_cfg_t c);
        word_t hy;
        word_t ez;
        addr_t off;
        for (int i = 0; i < int'(c.count); i++)
        begin
            off = addr_t'(i);
            hy  = fill_word(c.hy_base + off);
            ez  = fill_word(c.ez_base + off);
            check_word("hy update", hy + ez, mem[c.hy_base + off]);
            check_word("ez update", ez - hy, mem[c.ez_base + off]);
        end
        check_guards(c.hy_base, c.count);
        check_guards(c.ez_base, c.count);
    endtask

    task automatic check_untouched(input run_cfg_t c);
        addr_t off;
        for (int i = 0; i < int'(c.count); i++)
        begin
            off = addr_t'(i);
            check_word("hy untouched", fill_word(c.hy_base + off), mem[c.hy_base + off]);
            check_word("ez untouched", fill_word(c.ez_base + off), mem[c.ez_base + off]);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // directed tests
    ////////////////////////////////////////////////////////////

    task automatic test_idle();
        test_name = "idle";
        repeat (20)
        begin
            @(negedge ACLK);
            check_bit("busy", 1'b0, busy_o);
            check_bit("pending", 1'b0, int_pending_o);
            check_bit("int", 1'b0, int_o);
            check_bit("mem req", 1'b0, mem_req_o);
            check_bit("calc req", 1'b0, calc_req_o);
            check_bit("upd req", 1'b0, upd_req_o);
            check_bit("old word valid", 1'b0, old_word_o.valid);
        end
    endtask

    task automatic test_one_block();
        run_cfg_t c;
        test_name = "one block";
        c = '{hy_base: 16'h1000, ez_base: 16'h2000, count: count_t'(BLOCK_WORDS)};
        run_sweep(c);
        check_arrays(c);
    endtask

    task automatic test_multi_block();
        run_cfg_t c;
        test_name = "multi block";
        c = '{hy_base: 16'h3000, ez_base: 16'h3400, count: count_t'(2 * BLOCK_WORDS + 3)};
        rand_dly = 1'b1;
        run_sweep(c);
        check_arrays(c);
    endtask

    task automatic test_interrupt();
        run_cfg_t c;
        test_name = "interrupt";
        c = '{hy_base: 16'h4000, ez_base: 16'h4100, count: count_t'(IRQ_WORDS)};
        @(posedge ACLK);
        clr_int_i <= 1'b1;
        int_en_i  <= 1'b0;
        @(posedge ACLK);
        clr_int_i <= 1'b0;
        @(negedge ACLK);
        check_bit("pending cleared", 1'b0, int_pending_o);
        run_sweep(c);
        check_arrays(c);
        check_bit("pending after sweep", 1'b1, int_pending_o);
        check_bit("int masked", 1'b0, int_o);
        @(posedge ACLK);
        int_en_i <= 1'b1;
        @(negedge ACLK);
        check_bit("int enabled", 1'b1, int_o);
        @(posedge ACLK);
        clr_int_i <= 1'b1;
        @(posedge ACLK);
        clr_int_i <= 1'b0;
        @(negedge ACLK);
        check_bit("pending after clear", 1'b0, int_pending_o);
        check_bit("int after clear", 1'b0, int_o);
        @(posedge ACLK);
        int_en_i <= 1'b0;
    endtask

    task automatic test_start_busy();
        run_cfg_t a;
        run_cfg_t b;
        test_name = "start during busy";
        a = '{hy_base: 16'h5000, ez_base: 16'h5100, count: count_t'(BLOCK_WORDS)};
        b = '{hy_base: 16'h6000, ez_base: 16'h6100, count: count_t'(BLOCK_WORDS)};
        start_sweep(a);
        wait_busy();
        repeat (3) @(posedge ACLK);
        cfg_i   <= b;
        start_i <= 1'b1;
        @(posedge ACLK);
        start_i <= 1'b0;
        wait_sweep_end();
        check_arrays(a);
        check_untouched(b);
    endtask

    initial
    begin
        int cycles;
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES)
        begin
            @(posedge ACLK);
            cycles++;
        end
        $display("timeout: run still going after %0d cycles", TIMEOUT_CYCLES);
        $display("TB FAILED");
        $finish;
    end

    initial
    begin
        int chk_fails;
        ARESETn   <= 1'b0;
        start_i   <= 1'b0;
        cfg_i     <= '0;
        int_en_i  <= 1'b0;
        clr_int_i <= 1'b0;
        repeat (RESET_CYCLES) @(posedge ACLK);
        ARESETn <= 1'b1;
        test_idle();
        test_one_block();
        test_multi_block();
        test_interrupt();
        test_start_busy();
        chk_fails = u_fdtd_mem_ctrl.u_chk.fail_cnt;
        $display("run complete: %0d compare errors, %0d assertion failures",
                 err_count, chk_fails);
        if (err_count == 0 && chk_fails == 0)
            $display("TB PASSED");
        else
            $display("TB FAILED");
        $finish;
    end

endmodule

/* hdl/fdtd_bus_pkg.sv */
package fdtd_bus_pkg;

    import fdtd_cfg_pkg::*;

    ////////////////////////////////////////////////////////////
    // field select
    ////////////////////////////////////////////////////////////

    typedef enum logic {
        HY = 1'b0,
        EZ = 1'b1
    } field_e;

    ////////////////////////////////////////////////////////////
    // channel payloads
    ////////////////////////////////////////////////////////////

    // single word access, data ignored on reads
    typedef struct packed {
        logic  wr;
        addr_t addr;
        word_t data;
    } mem_cmd_t;

    // index counts from the start of the block
    typedef struct packed {
        field_e field;
        count_t idx;
    } upd_cmd_t;

    typedef struct packed {
        count_t len;
    } calc_cmd_t;

    // streamed to the engine as words are read
    typedef struct packed {
        logic   valid;
        field_e field;
        count_t idx;
        word_t  data;
    } old_word_t;

endpackage

/* hdl/fdtd_cfg_pkg.sv */
package fdtd_cfg_pkg;

    ////////////////////////////////////////////////////////////
    // widths
    ////////////////////////////////////////////////////////////

    // one field value per word
    localparam int WORD_W  = 32;

    // word addresses, no byte lanes
    localparam int ADDR_W  = 16;

    localparam int COUNT_W = 16;

    ////////////////////////////////////////////////////////////
    // basic types
    ////////////////////////////////////////////////////////////

    typedef logic [WORD_W-1:0]  word_t;
    typedef logic [ADDR_W-1:0]  addr_t;
    typedef logic [COUNT_W-1:0] count_t;

    ////////////////////////////////////////////////////////////
    // run configuration
    ////////////////////////////////////////////////////////////

    // both arrays hold count words from their own base
    typedef struct packed {
        addr_t  hy_base;
        addr_t  ez_base;
        count_t count;
    } run_cfg_t;

endpackage

/* hdl/fdtd_cmd_front.sv */
`timescale 1ns/1ns

module fdtd_cmd_front
    import fdtd_cfg_pkg::*;
(
    input  logic     ACLK,
    input  logic     ARESETn,

    input  logic     start_i,
    input  run_cfg_t cfg_i,
    input  logic     int_en_i,
    input  logic     clr_int_i,

    input  logic     busy_i,

    output logic     run_go_o,
    output run_cfg_t run_cfg_o,

    output logic     int_pending_o,
    output logic     int_o
);

    logic accept;
    logic busy_q;

    // busy only rises two cycles after the accept, so block that gap too
    assign accept = start_i & ~busy_i & ~run_go_o;

    always_ff @(posedge ACLK, negedge ARESETn)
    begin
        if (~ARESETn)
            run_go_o <= 1'b0;
        else
            run_go_o <= accept;
    end

    // held for the whole run
    always_ff @(posedge ACLK)
    begin
        if (accept)
            run_cfg_o <= cfg_i;
    end

    ////////////////////////////////////////////////////////////
    // interrupt
    ////////////////////////////////////////////////////////////

    always_ff @(posedge ACLK, negedge ARESETn)
    begin
        if (~ARESETn)
        begin
            busy_q        <= 1'b0;
            int_pending_o <= 1'b0;
        end
        else
        begin
            busy_q <= busy_i;
            if (clr_int_i)
                int_pending_o <= 1'b0;
            else if (busy_q & ~busy_i)
                int_pending_o <= 1'b1;
        end
    end

    assign int_o = int_en_i & int_pending_o;

endmodule

/* hdl/fdtd_hs_req.sv */
`timescale 1ns/1ns

module fdtd_hs_req
    import fdtd_cfg_pkg::*;
#(
    parameter type payload_t = logic
)
(
    input  logic     ACLK,
    input  logic     ARESETn,

    input  logic     go_i,
    input  payload_t payload_i,
    output logic     ready_o,
    output logic     done_o,
    output word_t    rsp_o,

    output logic     req_o,
    output payload_t payload_o,
    input  logic     ack_i,
    input  word_t    rsp_i
);

    typedef enum logic [1:0] {
        HS_IDLE,
        HS_REQ,
        HS_REL
    } hs_state_e;

    hs_state_e state_q;
    logic      ack_seen;

    assign ack_seen = (state_q == HS_REQ) && ack_i;

    always_ff @(posedge ACLK, negedge ARESETn)
    begin
        if (~ARESETn)
            state_q <= HS_IDLE;
        else
        begin
            case (state_q)
                HS_IDLE:
                    if (go_i)
                        state_q <= HS_REQ;
                HS_REQ:
                    if (ack_i)
                        state_q <= HS_REL;
                // wait for the responder to drop ack
                HS_REL:
                    if (~ack_i)
                        state_q <= HS_IDLE;
                default:
                    state_q <= HS_IDLE;
            endcase
        end
    end

    always_ff @(posedge ACLK, negedge ARESETn)
    begin
        if (~ARESETn)
            done_o <= 1'b0;
        else
            done_o <= ack_seen;
    end

    // payload held for the whole request
    always_ff @(posedge ACLK)
    begin
        if (go_i && ready_o)
            payload_o <= payload_i;
        if (ack_seen)
            rsp_o <= rsp_i;
    end

    assign ready_o = (state_q == HS_IDLE);
    assign req_o   = (state_q == HS_REQ);

endmodule

/* hdl/fdtd_mem_ctrl.sv */
`timescale 1ns/1ns

module fdtd_mem_ctrl
    import fdtd_cfg_pkg::*;
    import fdtd_bus_pkg::*;
#(
    parameter int unsigned BLOCK_WORDS = 8
)
(
    input  logic      ACLK,
    input  logic      ARESETn,

    input  logic      start_i,
    input  run_cfg_t  cfg_i,
    input  logic      int_en_i,
    input  logic      clr_int_i,
    output logic      busy_o,
    output logic      int_pending_o,
    output logic      int_o,

    output logic      mem_req_o,
    output mem_cmd_t  mem_cmd_o,
    input  logic      mem_ack_i,
    input  word_t     mem_rdata_i,

    output logic      calc_req_o,
    output calc_cmd_t calc_cmd_o,
    input  logic      calc_ack_i,

    output logic      upd_req_o,
    output upd_cmd_t  upd_cmd_o,
    input  logic      upd_ack_i,
    input  word_t     upd_data_i,

    output old_word_t old_word_o
);

    logic      run_go;
    run_cfg_t  run_cfg;
    logic      mem_go, mem_ready, mem_done;
    mem_cmd_t  mem_cmd;
    word_t     mem_rdata;
    logic      calc_go, calc_ready, calc_done;
    calc_cmd_t calc_cmd;
    logic      upd_go, upd_ready, upd_done;
    upd_cmd_t  upd_cmd;
    word_t     upd_data;

    fdtd_cmd_front u_front
    (
        .ACLK(ACLK), .ARESETn(ARESETn), .start_i(start_i), .cfg_i(cfg_i),
        .int_en_i(int_en_i), .clr_int_i(clr_int_i), .busy_i(busy_o),
        .run_go_o(run_go), .run_cfg_o(run_cfg), .int_pending_o(int_pending_o), .int_o(int_o)
    );

    fdtd_sweep_ctrl #(.BLOCK_WORDS(BLOCK_WORDS)) u_sweep
    (
        .ACLK(ACLK), .ARESETn(ARESETn), .run_go_i(run_go), .run_cfg_i(run_cfg),
        .busy_o(busy_o), .mem_go_o(mem_go), .mem_cmd_o(mem_cmd), .mem_ready_i(mem_ready),
        .mem_done_i(mem_done), .mem_rdata_i(mem_rdata), .calc_go_o(calc_go),
        .calc_cmd_o(calc_cmd), .calc_ready_i(calc_ready), .calc_done_i(calc_done),
        .upd_go_o(upd_go), .upd_cmd_o(upd_cmd), .upd_ready_i(upd_ready),
        .upd_done_i(upd_done), .upd_data_i(upd_data), .old_word_o(old_word_o)
    );

    fdtd_hs_req #(.payload_t(mem_cmd_t)) u_mem_hs
    (
        .ACLK(ACLK), .ARESETn(ARESETn), .go_i(mem_go), .payload_i(mem_cmd),
        .ready_o(mem_ready), .done_o(mem_done), .rsp_o(mem_rdata), .req_o(mem_req_o),
        .payload_o(mem_cmd_o), .ack_i(mem_ack_i), .rsp_i(mem_rdata_i)
    );

    // engine returns no data on the calculation channel
    fdtd_hs_req #(.payload_t(calc_cmd_t)) u_calc_hs
    (
        .ACLK(ACLK), .ARESETn(ARESETn), .go_i(calc_go), .payload_i(calc_cmd),
        .ready_o(calc_ready), .done_o(calc_done), .rsp_o(), .req_o(calc_req_o),
        .payload_o(calc_cmd_o), .ack_i(calc_ack_i), .rsp_i(word_t'(0))
    );

    fdtd_hs_req #(.payload_t(upd_cmd_t)) u_upd_hs
    (
        .ACLK(ACLK), .ARESETn(ARESETn), .go_i(upd_go), .payload_i(upd_cmd),
        .ready_o(upd_ready), .done_o(upd_done), .rsp_o(upd_data), .req_o(upd_req_o),
        .payload_o(upd_cmd_o), .ack_i(upd_ack_i), .rsp_i(upd_data_i)
    );

endmodule

/* hdl/fdtd_sweep_ctrl.sv */
`timescale 1ns/1ns

module fdtd_sweep_ctrl
    import fdtd_cfg_pkg::*;
    import fdtd_bus_pkg::*;
#(
    parameter int unsigned BLOCK_WORDS = 8
)
(
    input  logic      ACLK,
    input  logic      ARESETn,

    input  logic      run_go_i,
    input  run_cfg_t  run_cfg_i,
    output logic      busy_o,

    output logic      mem_go_o,
    output mem_cmd_t  mem_cmd_o,
    input  logic      mem_ready_i,
    input  logic      mem_done_i,
    input  word_t     mem_rdata_i,

    output logic      calc_go_o,
    output calc_cmd_t calc_cmd_o,
    input  logic      calc_ready_i,
    input  logic      calc_done_i,

    output logic      upd_go_o,
    output upd_cmd_t  upd_cmd_o,
    input  logic      upd_ready_i,
    input  logic      upd_done_i,
    input  word_t     upd_data_i,

    output old_word_t old_word_o
);

    typedef enum logic [3:0] {
        ST_IDLE,
        ST_RD_HY,
        ST_RD_EZ,
        ST_CALC,
        ST_UP_HY,
        ST_WR_HY,
        ST_UP_EZ,
        ST_WR_EZ,
        ST_FIN
    } sweep_state_e;

    sweep_state_e state_q;
    logic         pend_q;
    count_t       remain_q;
    count_t       blk_idx_q;
    count_t       idx_q;
    count_t       blk_len;
    count_t       blk_off;
    logic         last_word;
    logic         is_rd;
    logic         is_wr;
    field_e       cur_field;
    logic         old_valid_q;
    field_e       old_field_q;
    count_t       old_idx_q;
    word_t        old_data_q;

    ////////////////////////////////////////////////////////////
    // block geometry
    ////////////////////////////////////////////////////////////

    assign blk_len   = (remain_q < count_t'(BLOCK_WORDS)) ? remain_q : count_t'(BLOCK_WORDS);
    // every block but the last is full
    assign blk_off   = count_t'(blk_idx_q * BLOCK_WORDS);
    assign last_word = (idx_q == blk_len - count_t'(1));

    assign is_rd     = (state_q == ST_RD_HY) || (state_q == ST_RD_EZ);
    assign is_wr     = (state_q == ST_WR_HY) || (state_q == ST_WR_EZ);
    assign cur_field = (state_q == ST_RD_EZ || state_q == ST_UP_EZ || state_q == ST_WR_EZ)
                       ? EZ : HY;

    // one request outstanding at a time
    assign mem_go_o  = (is_rd || is_wr) && ~pend_q && mem_ready_i;
    assign calc_go_o = (state_q == ST_CALC) && ~pend_q && calc_ready_i;
    assign upd_go_o  = (state_q == ST_UP_HY || state_q == ST_UP_EZ) && ~pend_q && upd_ready_i;

    always_comb
    begin
        mem_cmd_o.wr   = is_wr;
        mem_cmd_o.addr = ((cur_field == EZ) ? run_cfg_i.ez_base : run_cfg_i.hy_base)
                         + addr_t'(blk_off) + addr_t'(idx_q);
        // fetched word stays in the update requester until its next fetch
        mem_cmd_o.data = is_wr ? upd_data_i : '0;
        calc_cmd_o.len = blk_len;
        upd_cmd_o.field = cur_field;
        upd_cmd_o.idx   = idx_q;
    end

    ////////////////////////////////////////////////////////////
    // phase machine
    ////////////////////////////////////////////////////////////

    always_ff @(posedge ACLK, negedge ARESETn)
    begin
        if (~ARESETn)
        begin
            state_q   <= ST_IDLE;
            pend_q    <= 1'b0;
            remain_q  <= '0;
            blk_idx_q <= '0;
            idx_q     <= '0;
        end
        else
        begin
            if (mem_go_o || calc_go_o || upd_go_o)
                pend_q <= 1'b1;
            else if (mem_done_i || calc_done_i || upd_done_i)
                pend_q <= 1'b0;

            case (state_q)
                ST_IDLE:
                    if (run_go_i)
                    begin
                        remain_q  <= run_cfg_i.count;
                        blk_idx_q <= '0;
                        idx_q     <= '0;
                        state_q   <= (run_cfg_i.count == '0) ? ST_FIN : ST_RD_HY;
                    end
                ST_RD_HY, ST_RD_EZ:
                    if (mem_done_i)
                    begin
                        idx_q <= last_word ? '0 : idx_q + count_t'(1);
                        if (last_word)
                            state_q <= (state_q == ST_RD_HY) ? ST_RD_EZ : ST_CALC;
                    end
                ST_CALC:
                    if (calc_done_i)
                        state_q <= ST_UP_HY;
                ST_UP_HY:
                    if (upd_done_i)
                        state_q <= ST_WR_HY;
                ST_UP_EZ:
                    if (upd_done_i)
                        state_q <= ST_WR_EZ;
                ST_WR_HY:
                    if (mem_done_i)
                    begin
                        idx_q   <= last_word ? '0 : idx_q + count_t'(1);
                        state_q <= last_word ? ST_UP_EZ : ST_UP_HY;
                    end
                ST_WR_EZ:
                    if (mem_done_i)
                    begin
                        idx_q <= last_word ? '0 : idx_q + count_t'(1);
                        if (~last_word)
                            state_q <= ST_UP_EZ;
                        else
                        begin
                            // block complete
                            remain_q  <= remain_q - blk_len;
                            blk_idx_q <= blk_idx_q + count_t'(1);
                            state_q   <= (remain_q == blk_len) ? ST_IDLE : ST_RD_HY;
                        end
                    end
                default:
                    state_q <= ST_IDLE;
            endcase
        end
    end

    assign busy_o = (state_q != ST_IDLE);

    ////////////////////////////////////////////////////////////
    // old word stream
    ////////////////////////////////////////////////////////////

    always_ff @(posedge ACLK, negedge ARESETn)
    begin
        if (~ARESETn)
            old_valid_q <= 1'b0;
        else
            old_valid_q <= is_rd && mem_done_i;
    end

    always_ff @(posedge ACLK)
    begin
        if (is_rd && mem_done_i)
        begin
            old_field_q <= cur_field;
            old_idx_q   <= idx_q;
            old_data_q  <= mem_rdata_i;
        end
    end

    assign old_word_o = '{valid: old_valid_q, field: old_field_q,
                          idx: old_idx_q, data: old_data_q};

endmodule

/* vlog.f */
hdl/fdtd_cfg_pkg.sv
hdl/fdtd_bus_pkg.sv
hdl/fdtd_hs_req.sv
hdl/fdtd_cmd_front.sv
hdl/fdtd_sweep_ctrl.sv
hdl/fdtd_mem_ctrl.sv
bench/fdtd_mem_ctrl_chk.sv
bench/fdtd_tb.sv
